/* common/dcache_defs.svh */
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// cache geometry

// associativity
`define DCACHE_WAYS 2

// 16 sets
`define DCACHE_INDEX_W 4

// byte offset within a line, 16 bytes per line
`define DCACHE_OFFSET_W 4

`define DCACHE_WORDS (1 << (`DCACHE_OFFSET_W - 2))

// whatever is left of a 32-bit address
`define DCACHE_TAG_W (32 - `DCACHE_INDEX_W - `DCACHE_OFFSET_W)

`endif

/* common/dcache_pkg.sv */
`include "dcache_defs.svh"

package dcache_pkg;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } req_size_e;

    typedef enum logic [1:0] {
        ST_IDLE      = 2'd0,
        ST_WRITEBACK = 2'd1, // dirty victim going out
        ST_REFILL    = 2'd2
    } dcache_state_e;

    // cpu request, held until cpu_addr_ok
    typedef struct packed {
        logic        wr;
        req_size_e   size;
        logic [31:0] addr;
        logic [31:0] wdata; // bytes already sit on their lanes
    } cpu_cmd_t;

    // one word per request
    typedef struct packed {
        logic        req;
        logic        wen;
        logic        wlast; // last word of a write-back burst
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_cmd_t;

    typedef struct packed {
        logic                     valid;
        logic                     dirty;
        logic [`DCACHE_TAG_W-1:0] tag;
    } line_meta_t;

endpackage

/* dcache/dcache_tag_ram.sv */
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_tag_ram (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`DCACHE_INDEX_W-1:0] index,
    input  logic                       wen,
    input  dcache_pkg::line_meta_t     wmeta,
    output dcache_pkg::line_meta_t     rmeta
);

    localparam int SETS = 1 << `DCACHE_INDEX_W;

    logic [SETS-1:0]          valid;
    logic                     dirty [SETS]; // only meaningful while valid
    logic [`DCACHE_TAG_W-1:0] tag [SETS];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
        end else if (wen) begin
            valid[index] <= wmeta.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wen) begin
            dirty[index] <= wmeta.dirty;
            tag[index]   <= wmeta.tag;
        end
    end

    // combinational read, so a hit is known in the request cycle
    assign rmeta = '{
        valid: valid[index],
        dirty: dirty[index],
        tag:   tag[index]
    };

endmodule

/* dcache/dcache_data_ram.sv */
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_data_ram (
    input  logic                           clk,
    input  logic [`DCACHE_INDEX_W-1:0]     index,
    input  logic [`DCACHE_WORDS*4-1:0]     byte_en,
    input  logic [`DCACHE_WORDS*32-1:0]    wline,
    output logic [`DCACHE_WORDS*32-1:0]    rline
);

    localparam int SETS  = 1 << `DCACHE_INDEX_W;
    localparam int BYTES = `DCACHE_WORDS * 4;

    logic [BYTES*8-1:0] lines [SETS];

    // byte_en bit b covers wline[8*b +: 8]
    // a cpu store enables up to 4 bytes of one word
    // a refill beat enables one whole word
    always_ff @(posedge clk) begin
        for (int b = 0; b < BYTES; b++) begin
            if (byte_en[b]) begin
                lines[index][b*8 +: 8] <= wline[b*8 +: 8];
            end
        end
    end

    assign rline = lines[index]; // whole line, word select is done in the top

endmodule

/* dcache/dcache_replacement.sv */
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_replacement #(
    parameter int WAY_W = $clog2(`DCACHE_WAYS)
)(
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`DCACHE_INDEX_W-1:0] index,
    input  logic                       advance,
    output logic [WAY_W-1:0]           victim_way
);

    localparam int SETS = 1 << `DCACHE_INDEX_W;

    logic [WAY_W-1:0] ptr [SETS]; // next way to evict, per set

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < SETS; s++) begin
                ptr[s] <= '0;
            end
        end else if (advance) begin
            if (ptr[index] == WAY_W'(`DCACHE_WAYS - 1)) begin
                ptr[index] <= '0;
            end else begin
                ptr[index] <= ptr[index] + 1'b1;
            end
        end
    end

    assign victim_way = ptr[index];

endmodule

/* dcache/dcache_controller.sv */
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_controller #(
    parameter int WAY_W = $clog2(`DCACHE_WAYS)
)(
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          cpu_req,
    input  dcache_pkg::cpu_cmd_t          cpu_cmd,
    input  logic                          hit,
    input  logic [WAY_W-1:0]              hit_way,
    input  logic [WAY_W-1:0]              victim_way,
    input  dcache_pkg::line_meta_t        victim_meta,
    input  logic                          mem_addr_ok,
    input  logic                          mem_data_ok,
    input  logic [31:0]                   mem_rdata,
    output dcache_pkg::dcache_state_e     state,
    output logic [`DCACHE_OFFSET_W-3:0]   word_idx,
    output logic [`DCACHE_WAYS-1:0]       line_wen,
    output logic [`DCACHE_WORDS*4-1:0]    byte_en,
    output logic [`DCACHE_WORDS*32-1:0]   wline,
    output dcache_pkg::line_meta_t        wmeta,
    output logic                          mem_req,
    output logic                          mem_wen,
    output logic                          wlast,
    output logic                          refill_done
);

    import dcache_pkg::*;

    localparam int WORD_W = `DCACHE_OFFSET_W - 2;
    localparam int TAG_LO = `DCACHE_INDEX_W + `DCACHE_OFFSET_W;

    dcache_state_e     next_state;
    logic              wait_data; // address accepted while the word is still in flight
    logic              word_done;
    logic              last_word;
    logic              write_hit;
    logic [3:0]        word_be;
    logic [WORD_W-1:0] cpu_word;

    assign cpu_word  = cpu_cmd.addr[`DCACHE_OFFSET_W-1:2];
    assign last_word = &word_idx;
    assign write_hit = (state == ST_IDLE) && cpu_req && hit && cpu_cmd.wr;

    // every transfer, read or write, completes with mem_data_ok
    assign word_done = (state != ST_IDLE) && mem_data_ok && (wait_data || mem_addr_ok);

    assign mem_req     = (state != ST_IDLE) && !wait_data;
    assign mem_wen     = state == ST_WRITEBACK;
    assign wlast       = (state == ST_WRITEBACK) && last_word;
    assign refill_done = (state == ST_REFILL) && word_done && last_word;

    always_comb begin
        case (cpu_cmd.size)
            SIZE_BYTE: word_be = 4'b0001 << cpu_cmd.addr[1:0];
            SIZE_HALF: word_be = 4'b0011 << cpu_cmd.addr[1:0];
            default:   word_be = 4'b1111;
        endcase
    end

    // store hit and refill beats share the line write port
    always_comb begin
        line_wen = '0;
        byte_en  = '0;
        wline    = {`DCACHE_WORDS{cpu_cmd.wdata}}; // enables pick the word
        wmeta    = '{valid: 1'b1, dirty: 1'b1, tag: cpu_cmd.addr[31:TAG_LO]};
        if (write_hit) begin
            line_wen[hit_way]          = 1'b1;
            byte_en[cpu_word*4 +: 4]   = word_be;
        end else if (state == ST_REFILL && word_done) begin
            line_wen[victim_way]       = 1'b1;
            byte_en[word_idx*4 +: 4]   = 4'hf;
            wline                      = {`DCACHE_WORDS{mem_rdata}};
            // line stays invalid until its last word lands
            wmeta = '{valid: last_word, dirty: 1'b0, tag: cpu_cmd.addr[31:TAG_LO]};
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (cpu_req && !hit) begin
                    if (victim_meta.valid && victim_meta.dirty) begin
                        next_state = ST_WRITEBACK;
                    end else begin
                        next_state = ST_REFILL;
                    end
                end
            end
            ST_WRITEBACK: begin
                if (word_done && last_word) begin
                    next_state = ST_REFILL;
                end
            end
            ST_REFILL: begin
                if (word_done && last_word) begin
                    next_state = ST_IDLE; // request retries as a hit
                end
            end
            default: next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_IDLE;
            word_idx  <= '0;
            wait_data <= 1'b0;
        end else begin
            state <= next_state;
            if (word_done) begin
                word_idx <= word_idx + 1'b1; // wraps to 0 after a burst
            end
            if (word_done) begin
                wait_data <= 1'b0;
            end else if (mem_req && mem_addr_ok) begin
                wait_data <= 1'b1;
            end
        end
    end

    // the miss is served for the request that caused it
    cpu_hold_a: assert property (@(posedge clk) disable iff (reset)
        state != ST_IDLE |-> cpu_req && $stable(cpu_cmd))
        else $error("cpu request changed while a miss was in progress");

endmodule

/* rtl/dcache_top.sv */
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cpu_req,
    input  dcache_pkg::cpu_cmd_t  cpu_cmd,
    output logic                  cpu_addr_ok,
    output logic                  cpu_data_ok,
    output logic [31:0]           data_rdata,
    output dcache_pkg::mem_cmd_t  mem,
    input  logic [31:0]           mem_rdata,
    input  logic                  mem_addr_ok,
    input  logic                  mem_data_ok
);

    import dcache_pkg::*;

    localparam int WAY_W  = $clog2(`DCACHE_WAYS);
    localparam int WORD_W = `DCACHE_OFFSET_W - 2;
    localparam int LINE_W = `DCACHE_WORDS * 32;
    localparam int BE_W   = `DCACHE_WORDS * 4;

    logic [`DCACHE_TAG_W-1:0]   addr_tag;
    logic [`DCACHE_INDEX_W-1:0] addr_index;
    logic [WORD_W-1:0]          addr_word;

    line_meta_t              way_meta [`DCACHE_WAYS];
    logic [LINE_W-1:0]       way_line [`DCACHE_WAYS];
    logic [`DCACHE_WAYS-1:0] way_hit;
    logic [`DCACHE_WAYS-1:0] line_wen;
    logic [WAY_W-1:0]        hit_way;
    logic [WAY_W-1:0]        victim_way;
    logic                    hit;
    logic                    refill_done;
    logic [BE_W-1:0]         byte_en;
    logic [LINE_W-1:0]       wline;
    line_meta_t              wmeta;
    line_meta_t              victim_meta;
    logic [LINE_W-1:0]       victim_line;
    dcache_state_e           state;
    logic [WORD_W-1:0]       word_idx;
    logic                    mem_req;
    logic                    mem_wen;
    logic                    mem_wlast;
    logic [31:0]             mem_addr;

    assign addr_tag   = cpu_cmd.addr[31 -: `DCACHE_TAG_W];
    assign addr_index = cpu_cmd.addr[`DCACHE_INDEX_W + `DCACHE_OFFSET_W - 1 : `DCACHE_OFFSET_W];
    assign addr_word  = cpu_cmd.addr[`DCACHE_OFFSET_W-1:2];

    for (genvar w = 0; w < `DCACHE_WAYS; w++) begin : g_way
        dcache_tag_ram u_tag (
            .clk   (clk),
            .reset (reset),
            .index (addr_index),
            .wen   (line_wen[w]),
            .wmeta (wmeta),
            .rmeta (way_meta[w])
        );

        dcache_data_ram u_data (
            .clk     (clk),
            .index   (addr_index),
            .byte_en (byte_en & {BE_W{line_wen[w]}}),
            .wline   (wline),
            .rline   (way_line[w])
        );

        assign way_hit[w] = way_meta[w].valid && (way_meta[w].tag == addr_tag);
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (way_hit[w]) begin
                hit_way |= WAY_W'(w);
            end
        end
    end

    assign hit         = (state == ST_IDLE) && |way_hit; // no hits while a miss is in progress
    assign cpu_addr_ok = cpu_req && hit;

    always_ff @(posedge clk) begin
        if (reset) begin
            cpu_data_ok <= 1'b0;
        end else begin
            cpu_data_ok <= cpu_addr_ok;
        end
    end

    // held for the data_ok cycle, cpu may already present the next address
    always_ff @(posedge clk) begin
        if (cpu_addr_ok) begin
            data_rdata <= way_line[hit_way][addr_word*32 +: 32];
        end
    end

    dcache_replacement #(.WAY_W(WAY_W)) u_repl (
        .clk        (clk),
        .reset      (reset),
        .index      (addr_index),
        .advance    (refill_done),
        .victim_way (victim_way)
    );

    assign victim_meta = way_meta[victim_way];
    assign victim_line = way_line[victim_way];

    dcache_controller #(.WAY_W(WAY_W)) u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .cpu_req     (cpu_req),
        .cpu_cmd     (cpu_cmd),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .victim_meta (victim_meta),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_rdata   (mem_rdata),
        .state       (state),
        .word_idx    (word_idx),
        .line_wen    (line_wen),
        .byte_en     (byte_en),
        .wline       (wline),
        .wmeta       (wmeta),
        .mem_req     (mem_req),
        .mem_wen     (mem_wen),
        .wlast       (mem_wlast),
        .refill_done (refill_done)
    );

    // write-back goes to the victim's old line, refill to the requested one
    assign mem_addr = (state == ST_WRITEBACK) ?
                      {victim_meta.tag, addr_index, word_idx, 2'b00} :
                      {addr_tag, addr_index, word_idx, 2'b00};

    assign mem = '{
        req:   mem_req,
        wen:   mem_wen,
        wlast: mem_wlast,
        addr:  mem_addr,
        wdata: victim_line[word_idx*32 +: 32]
    };

    // a tag lives in at most one way of a set
    way_hit_onehot_a: assert property (@(posedge clk) disable iff (reset)
        $onehot0(way_hit))
        else $error("tag present in more than one way");

    mem_hold_a: assert property (@(posedge clk) disable iff (reset)
        mem.req && !mem_addr_ok |=> $stable(mem.addr) && $stable(mem.wdata))
        else $error("memory request changed before mem_addr_ok");

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_NS = 50
)(
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_NS clk = ~clk; // 100 ns period
        end
    end

endmodule

/* tests/tb_dcache.sv */
`timescale 1ns/1ps
`include "dcache_defs.svh"

module tb_dcache;

    import dcache_pkg::*;

    localparam int NUM_OPS        = 1500;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 80;
    localparam int TAG_W          = `DCACHE_TAG_W;
    localparam int WORD_W         = `DCACHE_OFFSET_W - 2;
    localparam logic [31:0] LINE_MASK = (32'd1 << `DCACHE_OFFSET_W) - 1;

    logic        clk;
    logic        reset;
    logic        cpu_req;
    cpu_cmd_t    cpu_cmd;
    logic        cpu_addr_ok;
    logic        cpu_data_ok;
    logic [31:0] data_rdata;
    mem_cmd_t    mem;
    logic [31:0] mem_rdata;
    logic        mem_addr_ok;
    logic        mem_data_ok;

    logic [7:0]  gold_bytes [logic [31:0]]; // golden byte model
    logic [31:0] mem_words [logic [31:0]];  // backing memory, word addressed
    bit          line_seen [logic [31:0]];  // lines refilled at least once
    logic [TAG_W-1:0] tag_pool [4];

    int          errors = 0;
    int          cycles = 0;
    int          reads = 0;
    int          writes = 0;
    int          refills = 0;
    int          writebacks = 0;
    int          wb_cnt = 0;
    int          rf_cnt = 0;
    logic [31:0] wb_base;
    logic [31:0] cur_base;
    bit          checking = 0;
    bit          addr_ok_seen = 0;

    tb_clock clock_gen (.clk(clk));

    dcache_top dut (
        .clk         (clk),
        .reset       (reset),
        .cpu_req     (cpu_req),
        .cpu_cmd     (cpu_cmd),
        .cpu_addr_ok (cpu_addr_ok),
        .cpu_data_ok (cpu_data_ok),
        .data_rdata  (data_rdata),
        .mem         (mem),
        .mem_rdata   (mem_rdata),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok)
    );

    function automatic logic [31:0] addr_hash(input logic [31:0] a);
        return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic logic [31:0] golden_word(input logic [31:0] a);
        logic [31:0] w;
        logic [31:0] h;
        logic [31:0] ba;
        h = addr_hash({a[31:2], 2'b00});
        for (int b = 0; b < 4; b++) begin
            ba = {a[31:2], 2'(b)};
            w[b*8 +: 8] = gold_bytes.exists(ba) ? gold_bytes[ba] : h[b*8 +: 8];
        end
        return w;
    endfunction

    // lanes touched by an access of this size at this byte offset
    function automatic logic [31:0] lane_mask(input req_size_e size, input logic [1:0] off);
        case (size)
            SIZE_BYTE: return 32'h0000_00ff << (off * 8);
            SIZE_HALF: return 32'h0000_ffff << (off * 8);
            default:   return 32'hffff_ffff;
        endcase
    endfunction

    task automatic note_failure(input string what);
        errors++;
        $display("error at %0t: %s", $time, what);
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_mem_cmd(input string name, input mem_cmd_t got, input mem_cmd_t exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // burst order, addresses and write-back data, one call per memory request
    task automatic check_burst(input mem_cmd_t cmd);
        mem_cmd_t exp;
        if (cmd.wen) begin
            if (rf_cnt != 0) note_failure("write-back started inside a refill burst");
            if (wb_cnt == 0) begin
                wb_base = cmd.addr & ~LINE_MASK;
                writebacks++;
                if (!line_seen.exists(wb_base)) note_failure("write-back of a line never loaded");
            end
            exp.req   = 1'b1;
            exp.wen   = 1'b1;
            exp.wlast = (wb_cnt == `DCACHE_WORDS - 1);
            exp.addr  = wb_base + wb_cnt * 4;
            exp.wdata = golden_word(exp.addr);
            check_mem_cmd("mem", cmd, exp);
            wb_cnt = (wb_cnt + 1) % `DCACHE_WORDS;
        end else begin
            if (wb_cnt != 0) note_failure("refill started before the write-back burst ended");
            check_word("mem.addr", cmd.addr, cur_base + rf_cnt * 4);
            check_word("mem.wlast", 32'(cmd.wlast), 32'd0);
            rf_cnt++;
            if (rf_cnt == `DCACHE_WORDS) begin
                rf_cnt = 0;
                refills++;
                line_seen[cur_base] = 1'b1;
            end
        end
    endtask

    task automatic serve_memory();
        mem_cmd_t    cmd;
        int          addr_dly;
        int          data_dly;
        logic [31:0] wa;
        forever begin
            @(negedge clk);
            if (mem.req === 1'b1) begin
                cmd = mem;
                wa = {cmd.addr[31:2], 2'b00};
                addr_dly = $urandom_range(3);
                data_dly = $urandom_range(3);
                check_burst(cmd);
                @(posedge clk);
                #1;
                repeat (addr_dly) begin
                    @(posedge clk);
                    #1;
                end
                mem_addr_ok = 1'b1;
                if (cmd.wen) mem_words[wa] = cmd.wdata;
                if (data_dly == 0) begin
                    mem_data_ok = 1'b1;
                    mem_rdata = mem_words.exists(wa) ? mem_words[wa] : addr_hash(wa);
                end
                @(posedge clk);
                #1;
                mem_addr_ok = 1'b0;
                mem_data_ok = 1'b0;
                if (data_dly > 0) begin
                    repeat (data_dly - 1) begin
                        @(posedge clk);
                        #1;
                    end
                    mem_data_ok = 1'b1;
                    mem_rdata = mem_words.exists(wa) ? mem_words[wa] : addr_hash(wa);
                    @(posedge clk);
                    #1;
                    mem_data_ok = 1'b0;
                end
            end
        end
    endtask

    task automatic run_op();
        cpu_cmd_t             cmd;
        logic [TAG_W-1:0]     tag;
        logic [`DCACHE_INDEX_W-1:0] idx;
        logic [WORD_W-1:0]    word;
        logic [1:0]           off;
        logic [31:0]          mask;
        bit                   first;
        @(posedge clk);
        #1;
        cmd.wr   = $urandom_range(1);
        cmd.size = req_size_e'($urandom_range(2));
        tag      = tag_pool[$urandom_range(3)];
        idx      = $urandom_range((1 << `DCACHE_INDEX_W) - 1);
        word     = $urandom_range(`DCACHE_WORDS - 1);
        case (cmd.size)
            SIZE_BYTE: off = $urandom_range(3);
            SIZE_HALF: off = 2 * $urandom_range(1);
            default:   off = 2'd0;
        endcase
        cmd.addr  = {tag, idx, word, off};
        cmd.wdata = $urandom;
        cur_base  = cmd.addr & ~LINE_MASK;
        first     = !line_seen.exists(cur_base);
        mask      = lane_mask(cmd.size, off);
        cpu_cmd   = cmd;
        cpu_req   = 1'b1;
        if (cmd.wr) begin
            writes++;
            for (int b = 0; b < 4; b++) begin
                if (mask[b*8]) gold_bytes[{cmd.addr[31:2], 2'(b)}] = cmd.wdata[b*8 +: 8];
            end
        end else begin
            reads++;
        end
        do begin
            @(negedge clk);
        end while (cpu_addr_ok !== 1'b1);
        @(posedge clk);
        #1;
        cpu_req = 1'b0;
        @(negedge clk); // data_ok cycle
        if (!cmd.wr) check_word("data_rdata", data_rdata & mask, golden_word(cmd.addr) & mask);
        if (first && !line_seen.exists(cur_base)) note_failure("first access to a line gave no refill");
    endtask

    // every cpu_data_ok pairs with the cpu_addr_ok one cycle before
    always @(negedge clk) begin
        if (checking) begin
            if (cpu_data_ok === 1'b1 && !addr_ok_seen) begin
                note_failure("cpu_data_ok without a preceding cpu_addr_ok");
            end else if (cpu_data_ok !== 1'b1 && addr_ok_seen) begin
                note_failure("cpu_data_ok missing one cycle after cpu_addr_ok");
            end
            addr_ok_seen = (cpu_addr_ok === 1'b1);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h90d0a1ca));
        reset       = 1'b1;
        cpu_req     = 1'b0;
        cpu_cmd     = '0;
        mem_rdata   = '0;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        for (int i = 0; i < 4; i++) begin
            tag_pool[i] = TAG_W'(32'h3c5a1 * (i + 1)); // small pool, lots of conflicts
        end
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_word("cpu_addr_ok", 32'(cpu_addr_ok), 32'd0);
        check_word("cpu_data_ok", 32'(cpu_data_ok), 32'd0);
        check_word("mem.req", 32'(mem.req), 32'd0);
        check_word("mem.wlast", 32'(mem.wlast), 32'd0);
        checking = 1'b1;
        fork
            serve_memory();
        join_none
        for (int n = 0; n < NUM_OPS; n++) begin
            run_op();
        end
        $display("errors: %0d  reads: %0d  writes: %0d  refills: %0d  write-backs: %0d",
                 errors, reads, writes, refills, writebacks);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+common
common/dcache_pkg.sv
dcache/dcache_tag_ram.sv
dcache/dcache_data_ram.sv
dcache/dcache_replacement.sv
dcache/dcache_controller.sv
rtl/dcache_top.sv
tests/tb_clock.sv
tests/tb_dcache.sv
